/* filelist.f */
verilog/pe_pkg.sv
verilog/packet_decoder.sv
verilog/ifmap_buffer.sv
verilog/filter_buffer.sv
verilog/conv_engine.sv
verilog/psum_packetizer.sv
verilog/pe_top.sv
tests/pe_properties.sv
tests/pe_tb.sv

/* tests/pe_tb.sv */
// pe_tb: clock, reset, run table, reference psums, packet checks and closing summary

`timescale 1ns/1ps

module pe_tb
    import pe_pkg::*;
();

    localparam int DEPTH_I    = 25;
    localparam int DEPTH_F    = 5;
    localparam int N_OUT      = DEPTH_I - DEPTH_F + 1;
    localparam int N_RUNS     = 8;
    localparam int WAIT_LIMIT = 60;
    localparam int GAP        = 12;

    // header expected from element 3
    localparam int EXP_SOURCE = 3;
    localparam int EXP_DEST   = 13;
    localparam int EXP_X_DIR  = 0;
    localparam int EXP_X_HOP  = 0;
    localparam int EXP_Y_DIR  = 1;
    localparam int EXP_Y_HOP  = 1;

    typedef struct packed {
        logic [PAYLOAD_W-1:0]  weights;
        logic [DEPTH_I-1:0]    pixels;
        logic                  ifmap_first;
        logic                  intrude;
        pkt_kind_e             intrude_kind;
    } run_t;

    logic        clk;
    logic        arst_n;
    logic        pkt_valid;
    pe_packet_t  pkt_in;
    logic        out_valid;
    pe_packet_t  pkt_out;
    logic        busy;

    run_t runs [N_RUNS];
    int   exp_psum [N_RUNS][N_OUT];
    int   value_errors;
    int   timeout_errors;
    int   assert_errors;
    logic abort;

    pe_top UUT (
        .clk(clk), .arst_n(arst_n), .pkt_valid(pkt_valid), .pkt_in(pkt_in),
        .out_valid(out_valid), .pkt_out(pkt_out), .busy(busy)
    );

    bind pe_top pe_properties #(.N_OUT(DEPTH_I - DEPTH_F + 1)) u_props (
        .clk(clk), .arst_n(arst_n), .out_valid(out_valid), .busy(busy), .pkt_out(pkt_out)
    );

    always #20 clk = ~clk;

    // psum[i] = sum over j of weight[j] * pixel[i+j]
    function automatic int ref_psum(run_t r, int i);
        int sum;
        sum = 0;
        for (int j = 0; j < DEPTH_F; j++) begin
            sum += r.weights[j*WEIGHT_W +: WEIGHT_W] * r.pixels[i + j];
        end
        return sum;
    endfunction

    function automatic run_t make_run(logic [PAYLOAD_W-1:0] w, logic [DEPTH_I-1:0] p,
                                      logic order, logic intrude, pkt_kind_e kind);
        run_t r;
        r = '{weights: w, pixels: p, ifmap_first: order, intrude: intrude,
              intrude_kind: kind};
        return r;
    endfunction

    task automatic fill_table();
        runs[0] = make_run('0, '0, 1'b0, 1'b0, KIND_FILTER);
        runs[1] = make_run('1, '1, 1'b1, 1'b0, KIND_FILTER);
        // same rows in both orders
        // intruder kind is the partner of the next run's first packet
        runs[2] = make_run(40'h05_04_03_02_01, 25'h1555555, 1'b0, 1'b1, KIND_FILTER);
        runs[3] = make_run(40'h05_04_03_02_01, 25'h1555555, 1'b1, 1'b1, KIND_IFMAP);
        for (int r = 4; r < N_RUNS; r++) begin
            runs[r] = make_run(PAYLOAD_W'({$urandom(), $urandom()}), DEPTH_I'($urandom()),
                               r[0], (r >= 5), r[0] ? KIND_IFMAP : KIND_FILTER);
        end
        for (int r = 0; r < N_RUNS; r++) begin
            for (int i = 0; i < N_OUT; i++) begin
                exp_psum[r][i] = ref_psum(runs[r], i);
            end
        end
    endtask

    task automatic send_packet(input pkt_kind_e kind, input logic [PAYLOAD_W-1:0] data);
        @(negedge clk);
        if (busy) begin
            value_errors++;
            $display("ERROR %0t: busy high when a packet was offered", $time);
        end
        pkt_in          = '0;
        pkt_in.hdr.kind = kind;
        pkt_in.payload  = data;
        pkt_valid       = 1'b1;
        @(negedge clk);
        pkt_valid = 1'b0;
    endtask

    // element must stay quiet for the whole window
    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || busy !== 1'b0) begin
                value_errors++;
                $display("ERROR %0t: out_valid=%b busy=%b while idle expected",
                         $time, out_valid, busy);
            end
        end
    endtask

    task automatic wait_out(output logic got);
        got = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !got; n++) begin
            @(negedge clk);
            // an intruding packet lasts one cycle
            pkt_valid = 1'b0;
            if ($isunknown(out_valid)) begin
                value_errors++;
                $display("ERROR %0t: out_valid is unknown", $time);
            end
            got = (out_valid === 1'b1);
        end
    endtask

    task automatic check_psum(input int r, input int k);
        psum_payload_t p;
        route_hdr_t    h;
        p = pkt_out.payload;
        h = pkt_out.hdr;
        if (p.value !== PSUM_W'(exp_psum[r][k])) begin
            value_errors++;
            $display("ERROR %0t: run %0d psum %0d value %0d, expected %0d",
                     $time, r, k, p.value, exp_psum[r][k]);
        end
        if (p.addr !== PSUM_ADDR_W'(k)) begin
            value_errors++;
            $display("ERROR %0t: run %0d psum address %0d, expected %0d", $time, r, p.addr, k);
        end
        if (h.kind !== KIND_FILTER || h.source !== ID_W'(EXP_SOURCE)
                || h.dest !== ID_W'(EXP_DEST) || h.x_dir !== 1'(EXP_X_DIR)
                || h.x_hop !== XHOP_W'(EXP_X_HOP) || h.y_dir !== 1'(EXP_Y_DIR)
                || h.y_hop !== (YHOP_W + 1)'(EXP_Y_HOP)) begin
            value_errors++;
            $display("ERROR %0t: run %0d psum %0d header %h is wrong", $time, r, k, h);
        end
        if (busy !== 1'b1) begin
            value_errors++;
            $display("ERROR %0t: busy low during out_valid", $time);
        end
    endtask

    task automatic run_one(input int r);
        logic got;
        logic drained;
        logic [PAYLOAD_W-1:0] pix_data;
        pix_data = PAYLOAD_W'(runs[r].pixels);
        if (runs[r].ifmap_first) begin
            send_packet(KIND_IFMAP, pix_data);
        end else begin
            send_packet(KIND_FILTER, runs[r].weights);
        end
        // a lone packet must not start a run
        idle_check(GAP);
        if (runs[r].ifmap_first) begin
            send_packet(KIND_FILTER, runs[r].weights);
        end else begin
            send_packet(KIND_IFMAP, pix_data);
        end
        for (int k = 0; k < N_OUT; k++) begin
            wait_out(got);
            if (!got) begin
                timeout_errors++;
                $display("Timeout: run %0d, psum %0d never arrived", r, k);
                abort = 1'b1;
                return;
            end
            check_psum(r, k);
            if (runs[r].intrude && k == 2) begin
                pkt_in          = '0;
                pkt_in.hdr.kind = runs[r].intrude_kind;
                pkt_in.payload  = '1;
                pkt_valid       = 1'b1;
            end
        end
        // no psum past the last one, and busy has to fall
        drained = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !drained; n++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                value_errors++;
                $display("ERROR %0t: run %0d extra psum after %0d outputs", $time, r, N_OUT);
            end
            drained = (busy === 1'b0);
        end
        if (!drained) begin
            timeout_errors++;
            $display("Timeout: run %0d, busy never dropped after the last psum", r);
            abort = 1'b1;
        end
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        pkt_valid      = 1'b0;
        pkt_in         = '0;
        value_errors   = 0;
        timeout_errors = 0;
        assert_errors  = 0;
        abort          = 1'b0;
        void'($urandom(9));
        fill_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle_check(20);
        for (int r = 0; r < N_RUNS && !abort; r++) begin
            run_one(r);
        end
        assert_errors = UUT.u_props.assert_failures;
        $display("summary: value errors %0d, timeouts %0d, assertion failures %0d",
                 value_errors, timeout_errors, assert_errors);
        if (value_errors == 0 && timeout_errors == 0 && assert_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tests/pe_properties.sv */
// pe_properties: concurrent checks on output valid, busy level and psum address range

`timescale 1ns/1ps

module pe_properties
    import pe_pkg::*;
#(
    parameter int N_OUT = 21
) (
    input logic        clk,
    input logic        arst_n,
    input logic        out_valid,
    input logic        busy,
    input pe_packet_t  pkt_out
);

    psum_payload_t psum_fields;
    int            assert_failures = 0;

    assign psum_fields = pkt_out.payload;

    // a psum leaving the element follows its emit cycle, both inside the busy window
    valid_in_busy: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> busy && $past(busy))
        else begin
            assert_failures++;
            $error("out_valid high outside the busy window");
        end

    valid_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(out_valid))
        else begin
            assert_failures++;
            $error("out_valid is unknown after reset");
        end

    // one address per output of the run
    addr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        psum_fields.addr < N_OUT)
        else begin
            assert_failures++;
            $error("psum address %0d out of range", psum_fields.addr);
        end

endmodule

/* verilog/pe_top.sv */
// pe_top: processing element top level wiring decoder, buffers, engine and packetizer

`timescale 1ns/1ps

module pe_top
    import pe_pkg::*;
#(
    parameter int DEPTH_I = 25,
    parameter int DEPTH_F = 5,
    parameter int PE_ID   = 3
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pkt_valid,
    input  pe_packet_t  pkt_in,
    output logic        out_valid,
    output pe_packet_t  pkt_out,
    output logic        busy
);

    logic                        ifmap_load;
    logic                        filter_load;
    logic [PAYLOAD_W-1:0]        payload;
    logic                        consume;
    logic                        ifmap_ready;
    logic                        filter_ready;
    logic [$clog2(DEPTH_I)-1:0]  ifmap_addr;
    logic [$clog2(DEPTH_F)-1:0]  filter_addr;
    logic                        pixel;
    logic [WEIGHT_W-1:0]         weight;
    logic                        psum_valid;
    logic [PSUM_W-1:0]           psum_value;
    logic                        engine_busy;

    packet_decoder u_decoder (
        .clk(clk), .arst_n(arst_n), .pkt_valid(pkt_valid), .pkt_in(pkt_in), .busy(busy),
        .ifmap_load(ifmap_load), .filter_load(filter_load), .payload(payload)
    );

    ifmap_buffer #(.DEPTH_I(DEPTH_I)) u_ifmap (
        .clk(clk), .arst_n(arst_n), .ifmap_load(ifmap_load), .payload(payload),
        .consume(consume), .rd_addr(ifmap_addr), .pixel(pixel), .ready(ifmap_ready)
    );

    filter_buffer #(.DEPTH_F(DEPTH_F)) u_filter (
        .clk(clk), .arst_n(arst_n), .filter_load(filter_load), .payload(payload),
        .consume(consume), .rd_addr(filter_addr), .weight(weight), .ready(filter_ready)
    );

    conv_engine #(.DEPTH_I(DEPTH_I), .DEPTH_F(DEPTH_F)) u_engine (
        .clk(clk), .arst_n(arst_n), .ifmap_ready(ifmap_ready), .filter_ready(filter_ready),
        .pixel(pixel), .weight(weight), .ifmap_addr(ifmap_addr), .filter_addr(filter_addr),
        .consume(consume), .psum_valid(psum_valid), .psum_value(psum_value),
        .busy(engine_busy)
    );

    psum_packetizer #(.PE_ID(PE_ID)) u_packetizer (
        .clk(clk), .arst_n(arst_n), .consume(consume), .psum_valid(psum_valid),
        .psum_value(psum_value), .engine_busy(engine_busy), .out_valid(out_valid),
        .pkt_out(pkt_out), .busy(busy)
    );

endmodule

/* verilog/psum_packetizer.sv */
// psum_packetizer: psum address counter, output register and routed psum header

`timescale 1ns/1ps

module psum_packetizer
    import pe_pkg::*;
#(
    parameter int PE_ID = 3
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               consume,
    input  logic               psum_valid,
    input  logic [PSUM_W-1:0]  psum_value,
    input  logic               engine_busy,
    output logic               out_valid,
    output pe_packet_t         pkt_out,
    output logic               busy
);

    // header is fixed per element, elements 1-5 report to the low collector
    localparam route_hdr_t PSUM_HDR = '{
        kind:   KIND_FILTER,
        source: ID_W'(PE_ID),
        dest:   (PE_ID <= 5) ? ID_W'(PSUM_DEST_LOW) : ID_W'(PSUM_DEST_HIGH),
        x_dir:  ROUTE_TABLE[PE_ID].x_dir,
        x_hop:  ROUTE_TABLE[PE_ID].x_hop,
        y_dir:  ROUTE_TABLE[PE_ID].y_dir,
        y_hop:  (YHOP_W + 1)'(ROUTE_TABLE[PE_ID].y_hop)
    };

    logic [PSUM_ADDR_W-1:0] psum_addr;
    psum_payload_t          payload_q;

    // address restarts with every new run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            psum_addr <= '0;
            out_valid <= 1'b0;
            payload_q <= '0;
        end else begin
            out_valid <= psum_valid;
            if (consume) begin
                psum_addr <= '0;
            end else if (psum_valid) begin
                psum_addr <= psum_addr + 1'b1;
                payload_q <= '{addr: psum_addr, value: psum_value};
            end
        end
    end

    assign pkt_out = '{hdr: PSUM_HDR, payload: payload_q};

    // stay busy through the last registered psum
    assign busy = engine_busy || out_valid;

endmodule

/* verilog/conv_engine.sv */
// conv_engine: FSM for the 1-D convolution, tap sequencing, accumulator and psum output

`timescale 1ns/1ps

module conv_engine
    import pe_pkg::*;
#(
    parameter int DEPTH_I = 25,
    parameter int DEPTH_F = 5
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ifmap_ready,
    input  logic                        filter_ready,
    input  logic                        pixel,
    input  logic [WEIGHT_W-1:0]         weight,
    output logic [$clog2(DEPTH_I)-1:0]  ifmap_addr,
    output logic [$clog2(DEPTH_F)-1:0]  filter_addr,
    output logic                        consume,
    output logic                        psum_valid,
    output logic [PSUM_W-1:0]           psum_value,
    output logic                        busy
);

    localparam int N_OUT = DEPTH_I - DEPTH_F + 1;
    localparam int AI_W  = $clog2(DEPTH_I);
    localparam int AF_W  = $clog2(DEPTH_F);

    engine_state_e      state;
    logic [AI_W-1:0]    out_idx;
    logic [AF_W-1:0]    tap;
    logic [PSUM_W-1:0]  acc;
    logic               start;
    logic               last_tap;
    logic               last_out;

    assign start    = (state == ST_IDLE) && ifmap_ready && filter_ready;
    assign last_tap = (tap == AF_W'(DEPTH_F - 1));
    assign last_out = (out_idx == AI_W'(N_OUT - 1));

    // both rows are claimed on the start edge so new packets can refill them
    assign consume = start;

    // output i reads pixels i..i+DEPTH_F-1 against weights 0..DEPTH_F-1
    assign ifmap_addr  = out_idx + AI_W'(tap);
    assign filter_addr = tap;

    assign psum_valid = (state == ST_EMIT);
    assign psum_value = acc;
    assign busy       = (state != ST_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            out_idx <= '0;
            tap     <= '0;
            acc     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_MAC;
                        out_idx <= '0;
                        tap     <= '0;
                        acc     <= '0;
                    end
                end
                ST_MAC: begin
                    // 1-bit pixel gates the weight, no real multiplier needed
                    if (pixel) begin
                        acc <= acc + PSUM_W'(weight);
                    end
                    if (last_tap) begin
                        tap   <= '0;
                        state <= ST_EMIT;
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
                ST_EMIT: begin
                    acc <= '0;
                    if (last_out) begin
                        state <= ST_IDLE;
                    end else begin
                        out_idx <= out_idx + 1'b1;
                        state   <= ST_MAC;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/filter_buffer.sv */
// filter_buffer: weight row storage, ready flag and byte-wide read port

`timescale 1ns/1ps

module filter_buffer
    import pe_pkg::*;
#(
    parameter int DEPTH_F = 5
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        filter_load,
    input  logic [PAYLOAD_W-1:0]        payload,
    input  logic                        consume,
    input  logic [$clog2(DEPTH_F)-1:0]  rd_addr,
    output logic [WEIGHT_W-1:0]         weight,
    output logic                        ready
);

    logic [WEIGHT_W-1:0] weights [DEPTH_F];

    // weight j comes from byte lane j, lowest lane first
    always_ff @(posedge clk) begin
        if (filter_load) begin
            for (int j = 0; j < DEPTH_F; j++) begin
                weights[j] <= payload[j*WEIGHT_W +: WEIGHT_W];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else if (consume) begin
            ready <= 1'b0;
        end else if (filter_load) begin
            ready <= 1'b1;
        end
    end

    assign weight = weights[rd_addr];

endmodule

/* verilog/ifmap_buffer.sv */
// ifmap_buffer: pixel row storage, ready flag and single-bit read port

`timescale 1ns/1ps

module ifmap_buffer
    import pe_pkg::*;
#(
    parameter int DEPTH_I = 25
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ifmap_load,
    input  logic [PAYLOAD_W-1:0]        payload,
    input  logic                        consume,
    input  logic [$clog2(DEPTH_I)-1:0]  rd_addr,
    output logic                        pixel,
    output logic                        ready
);

    logic [DEPTH_I-1:0] pixels;

    // pixel k of the row is payload bit k
    always_ff @(posedge clk) begin
        if (ifmap_load) begin
            pixels <= payload[DEPTH_I-1:0];
        end
    end

    // a later load before the run simply overwrites the row
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else if (consume) begin
            ready <= 1'b0;
        end else if (ifmap_load) begin
            ready <= 1'b1;
        end
    end

    assign pixel = pixels[rd_addr];

endmodule

/* verilog/packet_decoder.sv */
// packet_decoder: input acceptance, payload register and per-kind load strobes

`timescale 1ns/1ps

module packet_decoder
    import pe_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pkt_valid,
    input  pe_packet_t            pkt_in,
    input  logic                  busy,
    output logic                  ifmap_load,
    output logic                  filter_load,
    output logic [PAYLOAD_W-1:0]  payload
);

    logic      accept;
    pkt_kind_e kind;

    // packets seen while a run is in flight are dropped here
    assign accept = pkt_valid && !busy;
    assign kind   = pkt_in.hdr.kind;

    // one strobe per accepted packet, selected by its kind
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifmap_load  <= 1'b0;
            filter_load <= 1'b0;
        end else begin
            ifmap_load  <= accept && (kind == KIND_IFMAP);
            filter_load <= accept && (kind == KIND_FILTER);
        end
    end

    // routing fields are not needed past this point, only the payload travels on
    always_ff @(posedge clk) begin
        if (accept) begin
            payload <= pkt_in.payload;
        end
    end

endmodule

/* verilog/pe_pkg.sv */
// pe_pkg: packet field widths, kind and state enums, header and packet structs, route table

package pe_pkg;

    localparam int PACKET_W    = 57;
    localparam int ID_W        = 4;
    localparam int PAYLOAD_W   = 40;
    localparam int WEIGHT_W    = 8;
    localparam int PSUM_W      = 13;
    localparam int PSUM_ADDR_W = 27;
    localparam int XHOP_W      = 3;
    localparam int YHOP_W      = 2;

    // psum collector nodes, one per row of elements
    localparam int PSUM_DEST_LOW  = 13;
    localparam int PSUM_DEST_HIGH = 14;

    // psums reuse the filter kind code
    typedef enum logic {
        KIND_FILTER = 1'b0,
        KIND_IFMAP  = 1'b1
    } pkt_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAC,
        ST_EMIT
    } engine_state_e;

    // y_hop lane spans bits 42:40 of the packet, hop count sits in its low bits
    typedef struct packed {
        pkt_kind_e           kind;
        logic [ID_W-1:0]     source;
        logic [ID_W-1:0]     dest;
        logic                x_dir;
        logic [XHOP_W-1:0]   x_hop;
        logic                y_dir;
        logic [YHOP_W:0]     y_hop;
    } route_hdr_t;

    typedef struct packed {
        route_hdr_t            hdr;
        logic [PAYLOAD_W-1:0]  payload;
    } pe_packet_t;

    typedef struct packed {
        logic [PSUM_ADDR_W-1:0] addr;
        logic [PSUM_W-1:0]      value;
    } psum_payload_t;

    typedef struct packed {
        logic               x_dir;
        logic [XHOP_W-1:0]  x_hop;
        logic               y_dir;
        logic [YHOP_W-1:0]  y_hop;
    } route_entry_t;

    // path from each element to its psum collector, indexed by element ID
    localparam route_entry_t ROUTE_TABLE [1:10] = '{
        '{1'b1, 3'd2, 1'b1, 2'd1},
        '{1'b1, 3'd1, 1'b1, 2'd1},
        '{1'b0, 3'd0, 1'b1, 2'd1},
        '{1'b0, 3'd1, 1'b1, 2'd1},
        '{1'b0, 3'd2, 1'b1, 2'd1},
        '{1'b1, 3'd3, 1'b1, 2'd2},
        '{1'b1, 3'd2, 1'b1, 2'd2},
        '{1'b1, 3'd1, 1'b1, 2'd2},
        '{1'b1, 3'd0, 1'b1, 2'd2},
        '{1'b0, 3'd1, 1'b1, 2'd2}
    };

endpackage
